// ==== verilog/tag_pkg.sv ====
/*
  shared definitions for the tag readout path
  - word geometry of the sample stream and the FIFO
  - APB bus widths and register offsets
  - tag_word_u, one FIFO word seen as samples or as a tag mask
*/

`default_nettype none

package tag_pkg;

  ////////////////////////////////////////////////////////////
  // stream and FIFO geometry
  ////////////////////////////////////////////////////////////

  // samples per beat, bits per sample
  localparam int NUM_CHANNELS  = 4;
  localparam int CHANNEL_WIDTH = 16;
  // FIFO write width
  localparam int DATA_WIDTH    = NUM_CHANNELS * CHANNEL_WIDTH;
  // tag bitmask on tuser
  localparam int NUM_TAGS      = 20;
  // FIFO read width, one APB data read
  localparam int READ_WIDTH    = 16;
  // narrow reads per wide word
  localparam int SLICES        = DATA_WIDTH / READ_WIDTH;
  // width of the count field in STATUS
  localparam int COUNT_WIDTH   = 8;

  ////////////////////////////////////////////////////////////
  // APB register map
  ////////////////////////////////////////////////////////////

  localparam int APB_ADDR_WIDTH = 8;
  localparam int APB_DATA_WIDTH = 32;

  localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS = 8'h00;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_DATA   = 8'h04;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL   = 8'h08;

  ////////////////////////////////////////////////////////////
  // FIFO word views
  ////////////////////////////////////////////////////////////

  // same 64 bits, decoded as channel samples or as the tag word
  // channel 0 sits in the low bits
  typedef union packed {
    logic [NUM_CHANNELS-1:0][CHANNEL_WIDTH-1:0] chan;
    struct packed {
      // zero fill above the mask
      logic [DATA_WIDTH-NUM_TAGS-1:0] pad;
      logic [NUM_TAGS-1:0]            mask;
    } tag;
  } tag_word_u;

endpackage

`default_nettype wire

// ==== verilog/tag_width_fifo.sv ====
/*
  tag_width_fifo
  synchronous FIFO, wide write port and narrow read port
  first word fall through, rd_data always shows the head slice
  lowest slice of a word is read first
  count reports narrow words still stored
*/

`timescale 1ns/1ns
`default_nettype none

module tag_width_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               flush,
  // write side, one wide word per write
  input  wire                               wr_en,
  input  wire  [tag_pkg::DATA_WIDTH-1:0]    wr_data,
  output logic                              full,
  // read side, one narrow slice per read
  input  wire                               rd_en,
  output logic [tag_pkg::READ_WIDTH-1:0]    rd_data,
  output logic                              empty,
  output logic [tag_pkg::COUNT_WIDTH-1:0]   count
);

  // pointer and slice index widths
  localparam int AW = $clog2(FIFO_DEPTH);
  localparam int SW = $clog2(tag_pkg::SLICES);
  // enough bits for a completely full FIFO in slices
  localparam int CW = $clog2(FIFO_DEPTH * tag_pkg::SLICES + 1);
  localparam int COUNT_MAX = 2 ** tag_pkg::COUNT_WIDTH - 1;

  // word storage
  logic [tag_pkg::DATA_WIDTH-1:0] mem [FIFO_DEPTH];

  // pointers carry one extra wrap bit
  logic [AW:0]   wr_ptr;
  logic [AW:0]   rd_ptr;
  logic [SW-1:0] slice;

  logic [AW:0]                    words;
  logic [CW-1:0]                  fill;
  logic [tag_pkg::DATA_WIDTH-1:0] head_word;
  logic                           do_wr;
  logic                           do_rd;

  ////////////////////////////////////////////////////////////
  // flags
  ////////////////////////////////////////////////////////////

  assign empty = (wr_ptr == rd_ptr);
  // same slot, different lap
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  // protect against misuse from either side
  assign do_wr = wr_en & ~full;
  assign do_rd = rd_en & ~empty;

  ////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr[AW-1:0]] <= wr_data;
    end
  end

  // flush drops everything, including a write in the same cycle
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wr_ptr <= '0;
    end else if (do_wr) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////

  // word pointer moves only after its last slice
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      rd_ptr <= '0;
      slice  <= '0;
    end else if (do_rd) begin
      if (slice == SW'(tag_pkg::SLICES - 1)) begin
        slice  <= '0;
        rd_ptr <= rd_ptr + 1'b1;
      end else begin
        slice <= slice + 1'b1;
      end
    end
  end

  // async read of the head word
  assign head_word = mem[rd_ptr[AW-1:0]];
  assign rd_data   = head_word[slice * tag_pkg::READ_WIDTH +: tag_pkg::READ_WIDTH];

  ////////////////////////////////////////////////////////////
  // narrow word count
  ////////////////////////////////////////////////////////////

  assign words = wr_ptr - rd_ptr;
  // stored words in slices, minus the part of the head already read
  assign fill  = CW'(words) * CW'(tag_pkg::SLICES) - CW'(slice);
  // saturate for deep FIFOs, status field is fixed
  assign count = (fill > COUNT_MAX) ? '1 : tag_pkg::COUNT_WIDTH'(fill);

endmodule

`default_nettype wire

// ==== verilog/tag_data_buff.sv ====
/*
  tag_data_buff
  stream slave in front of the width FIFO
  writes every accepted sample beat as one wide word
  after each frame, writes one tag word with the zero padded mask
  flags beats offered while the FIFO is full
*/

`timescale 1ns/1ns
`default_nettype none

module tag_data_buff (
  input  wire                             clk,
  input  wire                             rst,
  // stream slave
  input  wire                             s_tvalid,
  output logic                            s_tready,
  input  wire  [tag_pkg::DATA_WIDTH-1:0]  s_tdata,
  input  wire  [tag_pkg::NUM_TAGS-1:0]    s_tuser,
  input  wire                             s_tlast,
  // FIFO write side
  output logic                            wr_en,
  output logic [tag_pkg::DATA_WIDTH-1:0]  wr_data,
  input  wire                             full,
  // beat offered while full
  output logic                            overflow
);

  // tag word still owed for the frame just closed
  logic                         tag_pend;
  // mask captured from the last beat
  logic [tag_pkg::NUM_TAGS-1:0] tag_mask;
  logic                         beat_ok;
  tag_pkg::tag_word_u           word;

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  // blocked for the tag slot and whenever the FIFO is full
  assign s_tready = ~tag_pend & ~full;
  assign beat_ok  = s_tvalid & s_tready;

  // pulse only, sticky flag lives in the APB block
  assign overflow = s_tvalid & full;

  // normally set for exactly one cycle
  // held longer if the FIFO fills on the last beat
  always_ff @(posedge clk) begin
    if (rst) begin
      tag_pend <= 1'b0;
    end else if (beat_ok && s_tlast) begin
      tag_pend <= 1'b1;
    end else if (!full) begin
      tag_pend <= 1'b0;
    end
  end

  // tuser matters on the last beat only
  always_ff @(posedge clk) begin
    if (beat_ok && s_tlast) begin
      tag_mask <= s_tuser;
    end
  end

  ////////////////////////////////////////////////////////////
  // FIFO word
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (tag_pend) begin
      // tag view, mask in low bits
      word.tag.pad  = '0;
      word.tag.mask = tag_mask;
    end else begin
      // sample view, channel 0 lowest
      for (int i = 0; i < tag_pkg::NUM_CHANNELS; i++) begin
        word.chan[i] = s_tdata[i * tag_pkg::CHANNEL_WIDTH +: tag_pkg::CHANNEL_WIDTH];
      end
    end
  end

  // tag write and beat write never coincide, s_tready is low for the tag
  assign wr_en   = (tag_pend & ~full) | beat_ok;
  assign wr_data = word;

endmodule

`default_nettype wire

// ==== verilog/tag_apb_reader.sv ====
/*
  tag_apb_reader
  APB slave over the FIFO read side, zero wait states
  STATUS: not-empty, narrow word count, sticky overflow
  DATA: read returns the head slice and pops it
  CTRL: bit 0 flushes the FIFO and clears overflow
*/

`timescale 1ns/1ns
`default_nettype none

module tag_apb_reader (
  input  wire                                 clk,
  input  wire                                 rst,
  // APB slave
  input  wire                                 psel,
  input  wire                                 penable,
  input  wire                                 pwrite,
  input  wire  [tag_pkg::APB_ADDR_WIDTH-1:0]  paddr,
  input  wire  [tag_pkg::APB_DATA_WIDTH-1:0]  pwdata,
  output logic [tag_pkg::APB_DATA_WIDTH-1:0]  prdata,
  output logic                                pready,
  output logic                                pslverr,
  // FIFO read side
  input  wire  [tag_pkg::READ_WIDTH-1:0]      rd_data,
  input  wire                                 empty,
  input  wire  [tag_pkg::COUNT_WIDTH-1:0]     count,
  output logic                                rd_en,
  output logic                                flush,
  // pulse from the stream buffer
  input  wire                                 overflow
);

  logic access;
  logic sel_status;
  logic sel_data;
  logic sel_ctrl;
  logic data_rd;
  logic ovf_flag;

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  // access phase, always one cycle
  assign access     = psel & penable;
  assign sel_status = (paddr == tag_pkg::REG_STATUS);
  assign sel_data   = (paddr == tag_pkg::REG_DATA);
  assign sel_ctrl   = (paddr == tag_pkg::REG_CTRL);

  assign pready = 1'b1;

  assign data_rd = access & ~pwrite & sel_data;

  // pop at the end of the access phase, nothing if empty
  assign rd_en = data_rd & ~empty;
  // flush strobe from CTRL bit 0
  assign flush = access & pwrite & sel_ctrl & pwdata[0];

  // unknown address, or DATA read with nothing stored
  assign pslverr = access & ((~sel_status & ~sel_data & ~sel_ctrl) | (data_rd & empty));

  ////////////////////////////////////////////////////////////
  // sticky overflow
  ////////////////////////////////////////////////////////////

  // flush wins over a new overflow in the same cycle
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      ovf_flag <= 1'b0;
    end else if (overflow) begin
      ovf_flag <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    prdata = '0;
    if (sel_status) begin
      // bit 0 not-empty
      prdata[0]    = ~empty;
      // bits 15:8 narrow words stored
      prdata[15:8] = count;
      // bit 16 overflow since last flush
      prdata[16]   = ovf_flag;
    end else if (sel_data) begin
      // zero when empty
      if (!empty) begin
        prdata[tag_pkg::READ_WIDTH-1:0] = rd_data;
      end
    end
    // CTRL is write only, reads zero
  end

endmodule

`default_nettype wire

// ==== verilog/tag_readout_top.sv ====
/*
  tag_readout_top
  stream input -> tag_data_buff -> tag_width_fifo -> tag_apb_reader
  wires only
*/

`timescale 1ns/1ns
`default_nettype none

module tag_readout_top #(
  // wide words, power of two
  parameter int FIFO_DEPTH = 16
) (
  input  wire                                 clk,
  input  wire                                 rst,
  // sample stream
  input  wire                                 s_tvalid,
  output logic                                s_tready,
  input  wire  [tag_pkg::DATA_WIDTH-1:0]      s_tdata,
  input  wire  [tag_pkg::NUM_TAGS-1:0]        s_tuser,
  input  wire                                 s_tlast,
  // APB
  input  wire                                 psel,
  input  wire                                 penable,
  input  wire                                 pwrite,
  input  wire  [tag_pkg::APB_ADDR_WIDTH-1:0]  paddr,
  input  wire  [tag_pkg::APB_DATA_WIDTH-1:0]  pwdata,
  output logic [tag_pkg::APB_DATA_WIDTH-1:0]  prdata,
  output logic                                pready,
  output logic                                pslverr
);

  // FIFO write side
  logic                            wr_en;
  logic [tag_pkg::DATA_WIDTH-1:0]  wr_data;
  logic                            full;
  // FIFO read side
  logic                            rd_en;
  logic [tag_pkg::READ_WIDTH-1:0]  rd_data;
  logic                            empty;
  logic [tag_pkg::COUNT_WIDTH-1:0] count;
  logic                            flush;
  logic                            overflow;

  tag_data_buff i_tag_data_buff (
    .clk      (clk),
    .rst      (rst),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tdata  (s_tdata),
    .s_tuser  (s_tuser),
    .s_tlast  (s_tlast),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .full     (full),
    .overflow (overflow)
  );

  tag_width_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_tag_width_fifo (
    .clk     (clk),
    .rst     (rst),
    .flush   (flush),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .full    (full),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .empty   (empty),
    .count   (count)
  );

  tag_apb_reader i_tag_apb_reader (
    .clk      (clk),
    .rst      (rst),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .rd_data  (rd_data),
    .empty    (empty),
    .count    (count),
    .rd_en    (rd_en),
    .flush    (flush),
    .overflow (overflow)
  );

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
/*
  clock and reset for the testbench
  free running clock, synchronous active high reset
  reset drops a short delay after a rising edge
*/

`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // held for a fixed number of edges, released off the edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== dv/tag_readout_properties.sv ====
/*
  protocol properties bound into the readout top level
  stream payload held while a beat is stalled
  APB slave never inserts wait states
  FIFO never popped while empty
*/

`timescale 1ns/1ns
`default_nettype none

module tag_readout_properties (
  input wire                            clk,
  input wire                            rst,
  // stream side
  input wire                            s_tvalid,
  input wire                            s_tready,
  input wire [tag_pkg::DATA_WIDTH-1:0]  s_tdata,
  // APB side
  input wire                            pready,
  // FIFO read side
  input wire                            rd_en,
  input wire                            empty
);

  // a stalled beat keeps its payload until it is taken
  stalled_data_stable: assert property (
    @(posedge clk) disable iff (rst)
      (s_tvalid && !s_tready) |=> $stable(s_tdata)
  ) else $error("s_tdata changed while the beat was stalled");

  // zero wait states on every access
  pready_high: assert property (
    @(posedge clk) disable iff (rst) pready
  ) else $error("pready went low");

  // pops only with data present
  no_pop_when_empty: assert property (
    @(posedge clk) disable iff (rst) !(rd_en && empty)
  ) else $error("rd_en asserted while the FIFO was empty");

endmodule

`default_nettype wire

// ==== dv/tag_readout_tb.sv ====
/*
  testbench for the tag readout path
  stream stimulus with random samples and tags
  reference queue of expected narrow words, compare on every DATA read
  status, overflow, flush and bad address checks over APB
*/

`timescale 1ns/1ns
`default_nettype none

module tag_readout_tb;

  localparam int FIFO_DEPTH = 16;
  localparam int DW = tag_pkg::DATA_WIDTH;
  localparam int RW = tag_pkg::READ_WIDTH;
  localparam int CH = tag_pkg::CHANNEL_WIDTH;
  localparam int NT = tag_pkg::NUM_TAGS;
  localparam int SL = tag_pkg::SLICES;
  // cycles before a wait gives up
  localparam int WAIT_LIMIT = 100;

  logic                                clk;
  logic                                rst;
  logic                                s_tvalid;
  logic                                s_tready;
  logic [DW-1:0]                       s_tdata;
  logic [NT-1:0]                       s_tuser;
  logic                                s_tlast;
  logic                                psel;
  logic                                penable;
  logic                                pwrite;
  logic [tag_pkg::APB_ADDR_WIDTH-1:0]  paddr;
  logic [tag_pkg::APB_DATA_WIDTH-1:0]  pwdata;
  logic [tag_pkg::APB_DATA_WIDTH-1:0]  prdata;
  logic                                pready;
  logic                                pslverr;

  // expected narrow words, oldest first
  logic [RW-1:0] exp_q[$];
  logic          model_ovf;
  // last DATA read, handed to the compare process
  logic [31:0]   rd_val;
  logic          rd_err;
  event          data_done;
  int            stall_cycles;
  int            checks;
  int            errors;

  tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(5)) i_tb_clock (.clk(clk), .rst(rst));

  tag_readout_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_tag_readout_top (
    .clk      (clk),
    .rst      (rst),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tdata  (s_tdata),
    .s_tuser  (s_tuser),
    .s_tlast  (s_tlast),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr)
  );

  bind tag_readout_top tag_readout_properties i_tag_readout_properties (
    .clk      (clk),
    .rst      (rst),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tdata  (s_tdata),
    .pready   (pready),
    .rd_en    (rd_en),
    .empty    (empty)
  );

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // one wide word becomes SL narrow words, lowest slice first
  function automatic void model_word(input tag_pkg::tag_word_u w);
    logic [DW-1:0] bits;
    bits = w;
    for (int s = 0; s < SL; s++) begin
      exp_q.push_back(bits[s * RW +: RW]);
    end
  endfunction

  // frame end, mask zero padded to the full word
  function automatic void model_tag(input logic [NT-1:0] mask);
    tag_pkg::tag_word_u t;
    t.tag.pad  = '0;
    t.tag.mask = mask;
    model_word(t);
  endfunction

  function automatic tag_pkg::tag_word_u random_beat();
    tag_pkg::tag_word_u w;
    for (int i = 0; i < tag_pkg::NUM_CHANNELS; i++) begin
      w.chan[i] = CH'($urandom);
    end
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // run control
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    errors++;
    $display("run stopped: %s", why);
    $display("checks: %0d  errors: %0d", checks, errors);
    $display("Test failures found");
    $finish;
  endtask

  task automatic wait_reset_done();
    int n;
    n = 0;
    while (rst) begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT) abort_run("reset was never released");
    end
    @(posedge clk);
    #2;
  endtask

  ////////////////////////////////////////////////////////////
  // stream driver
  ////////////////////////////////////////////////////////////

  // holds the beat until taken, ready sampled mid cycle
  task automatic send_beat(input tag_pkg::tag_word_u beat, input logic last,
                           input logic [NT-1:0] mask);
    int   n;
    logic taken;
    n     = 0;
    taken = 1'b0;
    s_tvalid = 1'b1;
    s_tdata  = beat;
    s_tlast  = last;
    // tuser is junk except on the last beat
    s_tuser  = last ? mask : NT'($urandom);
    while (!taken) begin
      @(negedge clk);
      taken = s_tready;
      @(posedge clk);
      #2;
      if (!taken) begin
        n++;
        if (n > WAIT_LIMIT) abort_run("stream beat was never accepted");
      end
    end
    stall_cycles = n;
    model_word(beat);
    if (last) model_tag(mask);
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
  endtask

  task automatic send_frame(input int beats);
    logic [NT-1:0] mask;
    mask = NT'($urandom);
    for (int b = 0; b < beats; b++) begin
      send_beat(random_beat(), b == beats - 1, mask);
    end
    // tag slot right after the last beat
    @(negedge clk);
    checks++;
    assert (!s_tready) else begin
      errors++;
      $display("[ERROR] s_tready after last beat: got %h expected %h", s_tready, 1'b0);
    end
    @(posedge clk);
    #2;
  endtask

  ////////////////////////////////////////////////////////////
  // APB driver
  ////////////////////////////////////////////////////////////

  task automatic apb_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int n;
    n = 0;
    // setup phase
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk);
    while (!pready) begin
      n++;
      if (n > WAIT_LIMIT) abort_run("APB access never completed");
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic data_read();
    apb_access(1'b0, tag_pkg::REG_DATA, '0, rd_val, rd_err);
    -> data_done;
  endtask

  task automatic drain(input int reads);
    for (int i = 0; i < reads; i++) begin
      data_read();
    end
  endtask

  // expected STATUS built from the model
  task automatic check_status();
    logic [31:0] got;
    logic [31:0] want;
    logic        err;
    apb_access(1'b0, tag_pkg::REG_STATUS, '0, got, err);
    want       = '0;
    want[0]    = (exp_q.size() != 0);
    want[15:8] = 8'(exp_q.size());
    want[16]   = model_ovf;
    checks++;
    assert (got == want && !err) else begin
      errors++;
      $display("[ERROR] STATUS prdata: got %h expected %h, pslverr %h", got, want, err);
    end
  endtask

  task automatic check_bad_addr(input logic write, input logic [7:0] addr);
    logic [31:0] got;
    logic        err;
    apb_access(write, addr, 32'h1, got, err);
    checks++;
    assert (err) else begin
      errors++;
      $display("[ERROR] pslverr at address %h: got %h expected %h", addr, err, 1'b1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // compare process
  ////////////////////////////////////////////////////////////

  always @(data_done) begin : compare_data
    logic [RW-1:0] want;
    checks++;
    if (exp_q.size() == 0) begin
      // empty read, error response and zero data
      assert (rd_err && rd_val == '0) else begin
        errors++;
        $display("[ERROR] empty DATA read: pslverr %h prdata %h expected 1 and 0",
                 rd_err, rd_val);
      end
    end else begin
      want = exp_q.pop_front();
      assert (!rd_err && rd_val == {16'h0, want}) else begin
        errors++;
        $display("[ERROR] DATA prdata: got %h expected %h, pslverr %h", rd_val, want, rd_err);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    logic [31:0]        dummy;
    logic               err;
    tag_pkg::tag_word_u beat;
    void'($urandom(32'h41b7));
    s_tvalid  = 1'b0;
    s_tdata   = '0;
    s_tuser   = '0;
    s_tlast   = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    model_ovf = 1'b0;
    checks    = 0;
    errors    = 0;
    wait_reset_done();

    // out of reset, ready and empty
    checks++;
    assert (s_tready) else begin
      errors++;
      $display("[ERROR] s_tready after reset: got %h expected %h", s_tready, 1'b1);
    end
    check_status();
    data_read();

    // one frame, drained in order
    send_frame(5);
    drain(exp_q.size());
    check_status();

    // frames back to back, random lengths and tags
    for (int f = 0; f < 3; f++) begin
      send_frame(1 + int'($urandom % 3));
    end
    drain(exp_q.size());
    check_status();

    // fill to the top, then offer a last beat while full
    for (int b = 0; b < FIFO_DEPTH; b++) begin
      send_beat(random_beat(), 1'b0, '0);
    end
    check_status();
    beat = random_beat();
    fork
      send_beat(beat, 1'b1, NT'($urandom));
      drain(SL);
    join
    checks++;
    assert (stall_cycles > 0) else begin
      errors++;
      $display("beat offered to a full FIFO was accepted without a stall");
    end
    model_ovf = 1'b1;
    // frees a word for the pending tag
    drain(SL);
    check_status();
    drain(exp_q.size());
    check_status();

    // partial reads, then flush
    send_frame(3);
    drain(5);
    check_status();
    apb_access(1'b1, tag_pkg::REG_CTRL, 32'h1, dummy, err);
    checks++;
    assert (!err) else begin
      errors++;
      $display("[ERROR] pslverr on CTRL write: got %h expected %h", err, 1'b0);
    end
    exp_q.delete();
    model_ovf = 1'b0;
    check_status();
    data_read();

    // unknown addresses
    check_bad_addr(1'b0, 8'h0c);
    check_bad_addr(1'b1, 8'h20);

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // hard stop for the whole run
  initial begin : watchdog
    #2000000;
    abort_run("simulation time limit reached");
  end

endmodule

`default_nettype wire

// ==== tag_readout_top.f ====
verilog/tag_pkg.sv
verilog/tag_width_fifo.sv
verilog/tag_data_buff.sv
verilog/tag_apb_reader.sv
verilog/tag_readout_top.sv
dv/tb_clock.sv
dv/tag_readout_properties.sv
dv/tag_readout_tb.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tag_readout_tb
FILELIST ?= tag_readout_top.f
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP), result checked in $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qxF "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
